// ==== rtl/udp_echo_pkg.sv ====
//************************************************
// Shared types, defaults and FSM encodings of the
// UDP echo core, imported by the RTL modules
//************************************************

`default_nettype none

package udp_echo_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Defaults for the top level parameters
    localparam ip_addr_t  DEFAULT_LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // TTL written into every reply header
    localparam byte_t ECHO_TTL = 8'd64;

    // Receive header: src ip, src port, dst port, length
    localparam int RX_HDR_BYTES = 10;
    // Reply header: src ip, dst ip, src port, dst port, length, ttl
    localparam int TX_HDR_BYTES = 15;

    typedef enum logic [1:0] {
        RX_HEADER,
        RX_PAYLOAD,
        RX_DISCARD
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEADER,
        TX_PAYLOAD
    } tx_state_t;

endpackage

`default_nettype wire

// ==== rtl/byte_stream_if.sv ====
//************************************************
// Valid/ready byte stream with an end-of-frame flag
//************************************************

`timescale 1ns/10ps
`default_nettype none

interface byte_stream_if;

    logic                valid;
    logic                ready;
    udp_echo_pkg::byte_t data;
    logic                last;

    modport source (output valid, output data, output last, input ready);
    modport sink (input valid, input data, input last, output ready);

endinterface

`default_nettype wire

// ==== rtl/udp_hdr_if.sv ====
//************************************************
// One parsed UDP header, moved by valid/ready
//************************************************

`timescale 1ns/10ps
`default_nettype none

interface udp_hdr_if;

    logic                    valid;
    logic                    ready;
    udp_echo_pkg::ip_addr_t  src_ip;
    udp_echo_pkg::udp_port_t src_port;
    udp_echo_pkg::udp_port_t dst_port;
    udp_echo_pkg::udp_len_t  len;

    modport source (output valid, output src_ip, output src_port, output dst_port,
                    output len, input ready);
    modport sink (input valid, input src_ip, input src_port, input dst_port,
                  input len, output ready);

endinterface

`default_nettype wire

// ==== rtl/udp_rx_parser.sv ====
//************************************************
// Receive side of the echo core. Collects the 10-byte
// header into fields, then forwards payload bytes
// straight through until the last flag
//************************************************

`timescale 1ns/10ps
`default_nettype none

module udp_rx_parser (
    input  wire                 clk_125mhz,
    input  wire                 rst_125mhz,
    input  wire                 rx_valid,
    output logic                rx_ready,
    input  wire udp_echo_pkg::byte_t rx_data,
    input  wire                 rx_last,
    udp_hdr_if.source           hdr,
    byte_stream_if.source       pay
);
    import udp_echo_pkg::*;

    localparam int CNT_W = $clog2(RX_HDR_BYTES);
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(RX_HDR_BYTES - 1);

    rx_state_t                 state;
    logic [CNT_W-1:0]          hdr_cnt;
    logic [8*RX_HDR_BYTES-1:0] hdr_shift;
    logic                      hdr_valid;
    logic                      rx_fire;

    // Header bytes are held off while a parsed header waits
    always_comb begin
        unique case (state)
            RX_HEADER:  rx_ready = !hdr_valid;
            RX_PAYLOAD: rx_ready = pay.ready;
            default:    rx_ready = 1'b0;
        endcase
    end

    assign rx_fire = rx_valid && rx_ready;

    assign hdr.valid    = hdr_valid;
    assign hdr.src_ip   = hdr_shift[79:48];
    assign hdr.src_port = hdr_shift[47:32];
    assign hdr.dst_port = hdr_shift[31:16];
    assign hdr.len      = hdr_shift[15:0];

    assign pay.valid = rx_valid && (state == RX_PAYLOAD);
    assign pay.data  = rx_data;
    assign pay.last  = rx_last;

    always_ff @(posedge clk_125mhz) begin
        if (state == RX_HEADER && rx_fire) begin
            hdr_shift <= {hdr_shift[8*RX_HDR_BYTES-9:0], rx_data};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state     <= RX_HEADER;
            hdr_cnt   <= '0;
            hdr_valid <= 1'b0;
        end else begin
            unique case (state)
                RX_HEADER: begin
                    if (hdr_valid) begin
                        if (hdr.ready) begin
                            hdr_valid <= 1'b0;
                            hdr_cnt   <= '0;
                            state     <= RX_PAYLOAD;
                        end
                    end else if (rx_fire) begin
                        // A frame ending inside its header is thrown away
                        if (rx_last) begin
                            state <= RX_DISCARD;
                        end else if (hdr_cnt == LAST_IDX) begin
                            hdr_valid <= 1'b1;
                        end else begin
                            hdr_cnt <= hdr_cnt + 1'b1;
                        end
                    end
                end
                RX_PAYLOAD: begin
                    if (rx_fire && rx_last) begin
                        state <= RX_HEADER;
                    end
                end
                default: begin
                    hdr_cnt <= '0;
                    state   <= RX_HEADER;
                end
            endcase
        end
    end

    a_hdr_stable: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        hdr.valid && !hdr.ready |=> hdr.valid &&
            $stable({hdr.src_ip, hdr.src_port, hdr.dst_port, hdr.len}))
        else $error("header fields changed while waiting");

endmodule

`default_nettype wire

// ==== rtl/echo_port_filter.sv ====
//************************************************
// Echo or drop decision per datagram. Matching
// headers go on to the builder and their payload to
// the FIFO, all others are swallowed
//************************************************

`timescale 1ns/10ps
`default_nettype none

module echo_port_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT
) (
    input  wire            clk_125mhz,
    input  wire            rst_125mhz,
    udp_hdr_if.sink        rx_hdr,
    byte_stream_if.sink    rx_pay,
    udp_hdr_if.source      tx_hdr,
    byte_stream_if.source  fifo_in
);

    logic port_match;
    logic match_reg;
    logic drop_reg;

    assign port_match = (rx_hdr.dst_port == ECHO_PORT);

    // Dropped headers are taken at once
    assign tx_hdr.valid    = rx_hdr.valid && port_match;
    assign rx_hdr.ready    = port_match ? tx_hdr.ready : 1'b1;
    assign tx_hdr.src_ip   = rx_hdr.src_ip;
    assign tx_hdr.src_port = rx_hdr.src_port;
    assign tx_hdr.dst_port = rx_hdr.dst_port;
    assign tx_hdr.len      = rx_hdr.len;

    assign fifo_in.valid = rx_pay.valid && match_reg;
    assign fifo_in.data  = rx_pay.data;
    assign fifo_in.last  = rx_pay.last;
    assign rx_pay.ready  = (fifo_in.ready && match_reg) || drop_reg;

    // Decision lives from header transfer to the last payload byte
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            match_reg <= 1'b0;
            drop_reg  <= 1'b0;
        end else if (rx_hdr.valid && rx_hdr.ready) begin
            match_reg <= port_match;
            drop_reg  <= !port_match;
        end else if (rx_pay.valid && rx_pay.ready && rx_pay.last) begin
            match_reg <= 1'b0;
            drop_reg  <= 1'b0;
        end
    end

    a_one_decision: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        !(match_reg && drop_reg))
        else $error("match and drop both set");

    a_pay_decided: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        rx_pay.valid |-> (match_reg || drop_reg))
        else $error("payload arrived before its header was decided");

endmodule

`default_nettype wire

// ==== rtl/payload_fifo.sv ====
//************************************************
// Byte FIFO for echoed payload. Each entry keeps the
// data byte and its last flag; depth is a power of two
//************************************************

`timescale 1ns/10ps
`default_nettype none

module payload_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  wire            clk_125mhz,
    input  wire            rst_125mhz,
    byte_stream_if.sink    wr,
    byte_stream_if.source  rd
);
    import udp_echo_pkg::*;

    localparam int ADDR_W  = $clog2(FIFO_DEPTH);
    localparam int ENTRY_W = $bits(byte_t) + 1;
    localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W + 1)'(FIFO_DEPTH);

    if ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
        $error("FIFO_DEPTH must be a power of two");
    end

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [ADDR_W:0]    count;
    logic               wr_fire;
    logic               rd_fire;

    assign wr.ready = (count != FULL_COUNT);
    assign rd.valid = (count != '0);
    assign {rd.last, rd.data} = mem[rd_ptr];

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;

    always_ff @(posedge clk_125mhz) begin
        if (wr_fire) begin
            mem[wr_ptr] <= {wr.last, wr.data};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy only moves when one side transfers alone
            unique case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        (count == FULL_COUNT) && !rd_fire |=> (count == FULL_COUNT) && $stable(wr_ptr))
        else $error("write accepted into a full FIFO");

endmodule

`default_nettype wire

// ==== rtl/udp_tx_builder.sv ====
//************************************************
// Transmit side of the echo core. Sends the 15-byte
// reply header built from the latched receive header,
// then the buffered payload; shows the first payload
// byte of each reply on the LEDs
//************************************************

`timescale 1ns/10ps
`default_nettype none

module udp_tx_builder #(
    parameter udp_echo_pkg::ip_addr_t LOCAL_IP = udp_echo_pkg::DEFAULT_LOCAL_IP
) (
    input  wire                  clk_125mhz,
    input  wire                  rst_125mhz,
    udp_hdr_if.sink              hdr,
    byte_stream_if.sink          pay,
    output logic                 tx_valid,
    input  wire                  tx_ready,
    output udp_echo_pkg::byte_t  tx_data,
    output logic                 tx_last,
    output udp_echo_pkg::byte_t  led
);
    import udp_echo_pkg::*;

    localparam int IDX_W = $clog2(TX_HDR_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(TX_HDR_BYTES - 1);

    tx_state_t                 state;
    logic [IDX_W-1:0]          hdr_idx;
    logic                      first_pay;
    logic                      pay_fire;
    ip_addr_t                  peer_ip;
    udp_port_t                 peer_port;
    udp_port_t                 local_port;
    udp_len_t                  reply_len;
    logic [8*TX_HDR_BYTES-1:0] reply_hdr;
    byte_t                     hdr_byte;

    // Ports swap: the reply comes from the port the sender addressed
    always_ff @(posedge clk_125mhz) begin
        if (hdr.valid && hdr.ready) begin
            peer_ip    <= hdr.src_ip;
            peer_port  <= hdr.src_port;
            local_port <= hdr.dst_port;
            reply_len  <= hdr.len;
        end
    end

    assign reply_hdr = {LOCAL_IP, peer_ip, local_port, peer_port, reply_len, ECHO_TTL};
    // Byte 0 is the most significant one
    assign hdr_byte  = reply_hdr[8*(TX_HDR_BYTES - 1 - int'(hdr_idx)) +: 8];

    assign hdr.ready = (state == TX_IDLE);
    assign pay.ready = (state == TX_PAYLOAD) && tx_ready;
    assign pay_fire  = pay.valid && pay.ready;

    always_comb begin
        unique case (state)
            TX_HEADER:  tx_valid = 1'b1;
            TX_PAYLOAD: tx_valid = pay.valid;
            default:    tx_valid = 1'b0;
        endcase
    end

    assign tx_data = (state == TX_PAYLOAD) ? pay.data : hdr_byte;
    assign tx_last = (state == TX_PAYLOAD) && pay.last;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state     <= TX_IDLE;
            hdr_idx   <= '0;
            first_pay <= 1'b0;
            led       <= '0;
        end else begin
            unique case (state)
                TX_IDLE: begin
                    if (hdr.valid && hdr.ready) begin
                        hdr_idx   <= '0;
                        first_pay <= 1'b1;
                        state     <= TX_HEADER;
                    end
                end
                TX_HEADER: begin
                    if (tx_ready) begin
                        if (hdr_idx == LAST_IDX) begin
                            state <= TX_PAYLOAD;
                        end else begin
                            hdr_idx <= hdr_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (pay_fire) begin
                        first_pay <= 1'b0;
                        if (first_pay) begin
                            led <= pay.data;
                        end
                        if (pay.last) begin
                            state <= TX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    a_tx_hold: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
        else $error("transmit byte changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/udp_echo_top.sv ====
//************************************************
// UDP echo core top level. Plain valid/ready byte
// ports for receive and transmit, LED byte output
//************************************************

`timescale 1ns/10ps
`default_nettype none

module udp_echo_top #(
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP   = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter udp_echo_pkg::udp_port_t ECHO_PORT  = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter int                      FIFO_DEPTH = 64
) (
    input  wire                      clk_125mhz,
    input  wire                      rst_125mhz,
    input  wire                      rx_valid,
    output logic                     rx_ready,
    input  wire udp_echo_pkg::byte_t rx_data,
    input  wire                      rx_last,
    output logic                     tx_valid,
    input  wire                      tx_ready,
    output udp_echo_pkg::byte_t      tx_data,
    output logic                     tx_last,
    output udp_echo_pkg::byte_t      led
);

    byte_stream_if rx_pay ();
    byte_stream_if fifo_in ();
    byte_stream_if fifo_out ();
    udp_hdr_if     rx_hdr ();
    udp_hdr_if     tx_hdr ();

    udp_rx_parser u_udp_rx_parser (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data),
        .rx_last    (rx_last),
        .hdr        (rx_hdr),
        .pay        (rx_pay)
    );

    echo_port_filter #(
        .ECHO_PORT (ECHO_PORT)
    ) u_echo_port_filter (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .rx_hdr     (rx_hdr),
        .rx_pay     (rx_pay),
        .tx_hdr     (tx_hdr),
        .fifo_in    (fifo_in)
    );

    payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_payload_fifo (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .wr         (fifo_in),
        .rd         (fifo_out)
    );

    udp_tx_builder #(
        .LOCAL_IP (LOCAL_IP)
    ) u_udp_tx_builder (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .hdr        (tx_hdr),
        .pay        (fifo_out),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_data    (tx_data),
        .tx_last    (tx_last),
        .led        (led)
    );

endmodule

`default_nettype wire

// ==== verification/tb_udp_echo.sv ====
//************************************************
// Self-checking random testbench for the UDP echo
// core. Replies are predicted by a model queue and
// checked byte by byte on the transmit port
//************************************************

`timescale 1ns/10ps
`default_nettype none

module tb_udp_echo;

    localparam int          CLK_PERIOD  = 8;
    localparam int          FIFO_DEPTH  = 64;
    localparam logic [31:0] SEED        = 32'h29c6_34f2;
    localparam logic [31:0] LOCAL_IP    = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [15:0] ECHO_PORT   = 16'd1234;
    localparam logic [7:0]  TTL         = 8'd64;
    localparam int          NUM_RANDOM  = 150;
    localparam int          NUM_DGRAMS  = NUM_RANDOM + 3;
    // Worst case bytes per datagram, scaled for gaps and stalls
    localparam int          MAX_BYTES   = NUM_DGRAMS * (10 + 100 + 15);
    localparam int          WATCHDOG_NS = MAX_BYTES * 12 * CLK_PERIOD;
    // Longest single reply under heavy stalls, with a wide margin
    localparam int          DRAIN_LIMIT = (15 + 100) * 40;

    logic        clk_125mhz;
    logic        rst_125mhz;
    logic        rx_valid;
    logic        rx_ready;
    logic [7:0]  rx_data;
    logic        rx_last;
    logic        tx_valid;
    logic        tx_ready;
    logic [7:0]  tx_data;
    logic        tx_last;
    logic [7:0]  led;

    logic [31:0] drv_state;
    logic [31:0] stall_state;
    logic [7:0]  stall_level;
    logic [8:0]  exp_q[$];
    logic [7:0]  led_q[$];
    logic [7:0]  led_exp;
    logic        led_pending;

    udp_echo_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_udp_echo_top (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data),
        .rx_last    (rx_last),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_data    (tx_data),
        .tx_last    (tx_last),
        .led        (led)
    );

    initial begin
        clk_125mhz = 1'b0;
        forever #(CLK_PERIOD / 2) clk_125mhz = ~clk_125mhz;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        drv_state = xorshift(drv_state);
        return drv_state;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    // One byte on the receive port, sometimes after an idle gap
    task automatic send_byte(input logic [7:0] d, input logic l);
        logic [31:0] r;
        logic        accepted;
        r = next_rand();
        if (r[1:0] == 2'd0) begin
            rx_valid <= 1'b0;
            repeat (1 + r[3:2]) @(posedge clk_125mhz);
        end
        rx_valid <= 1'b1;
        rx_data  <= d;
        rx_last  <= l;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_125mhz);
            accepted = rx_ready;
            @(posedge clk_125mhz);
        end
    endtask

    // A cut_len above zero ends the frame early with last on that byte
    task automatic send_datagram(input logic [15:0] dst, input int pay_len,
                                 input int cut_len);
        logic [7:0]  frame [0:109];
        logic [31:0] r;
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [15:0] udp_len;
        int          total;
        src_ip = next_rand();
        r = next_rand();
        src_port = r[15:0];
        udp_len = 16'(pay_len + 8);
        for (int k = 0; k < 4; k++) begin
            frame[k] = src_ip[8*(3-k) +: 8];
        end
        frame[4] = src_port[15:8];
        frame[5] = src_port[7:0];
        frame[6] = dst[15:8];
        frame[7] = dst[7:0];
        frame[8] = udp_len[15:8];
        frame[9] = udp_len[7:0];
        for (int k = 0; k < pay_len; k++) begin
            r = next_rand();
            frame[10+k] = r[7:0];
        end
        total = (cut_len != 0) ? cut_len : 10 + pay_len;
        if (cut_len == 0 && dst == ECHO_PORT) begin
            // Reply: local ip, sender ip, swapped ports, length, ttl
            for (int k = 0; k < 4; k++) begin
                exp_q.push_back({1'b0, LOCAL_IP[8*(3-k) +: 8]});
            end
            for (int k = 0; k < 4; k++) begin
                exp_q.push_back({1'b0, src_ip[8*(3-k) +: 8]});
            end
            exp_q.push_back({1'b0, dst[15:8]});
            exp_q.push_back({1'b0, dst[7:0]});
            exp_q.push_back({1'b0, src_port[15:8]});
            exp_q.push_back({1'b0, src_port[7:0]});
            exp_q.push_back({1'b0, udp_len[15:8]});
            exp_q.push_back({1'b0, udp_len[7:0]});
            exp_q.push_back({1'b0, TTL});
            for (int k = 0; k < pay_len; k++) begin
                exp_q.push_back({k == pay_len - 1, frame[10+k]});
            end
            led_q.push_back(frame[10]);
        end
        for (int k = 0; k < total; k++) begin
            send_byte(frame[k], k == total - 1);
        end
    endtask

    // Random stalls on the transmit side
    always @(posedge clk_125mhz) begin
        stall_state <= xorshift(stall_state);
        tx_ready    <= (stall_state[7:0] >= stall_level);
    end

    always @(negedge clk_125mhz) begin
        if (!rst_125mhz) begin
            if (led_pending) begin
                check_value(32'(led), 32'(led_exp), "led after reply");
                led_pending = 1'b0;
            end
            if (tx_valid && tx_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("Transmit port sent a byte while no reply was expected");
                end else begin
                    check_value(32'({tx_last, tx_data}), 32'(exp_q.pop_front()),
                                "transmit {last, data}");
                    if (tx_last) begin
                        led_exp     = led_q.pop_front();
                        led_pending = 1'b1;
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("Watchdog timeout: the echo core stopped making progress");
    end

    initial begin
        logic [31:0] r;
        logic [15:0] dst;
        int          pay_len;
        int          cut_len;
        int          drain_cycles;
        rst_125mhz  = 1'b1;
        rx_valid    = 1'b0;
        rx_data     = 8'h00;
        rx_last     = 1'b0;
        tx_ready    = 1'b0;
        drv_state   = SEED;
        stall_state = SEED;
        stall_level = 8'd0;
        led_exp     = 8'h00;
        led_pending = 1'b0;
        repeat (16) @(posedge clk_125mhz);
        rst_125mhz <= 1'b0;
        @(negedge clk_125mhz);
        check_value(32'(led), 32'h0, "led after reset");
        check_value(32'(rx_ready), 32'h1, "rx_ready after reset");
        @(posedge clk_125mhz);

        // Echo, then a frame cut inside its header, then echo again
        send_datagram(ECHO_PORT, 4, 0);
        send_datagram(ECHO_PORT, 7, 6);
        send_datagram(ECHO_PORT, 16, 0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            // No stalls first, then moderate, then heavy back-pressure
            stall_level <= (i < 50) ? 8'd0 : ((i < 100) ? 8'd128 : 8'd200);
            r = next_rand();
            dst = (r[2:0] < 3'd5) ? ECHO_PORT : r[31:16];
            if (r[2:0] >= 3'd5 && dst == ECHO_PORT) begin
                dst = dst + 16'd1;
            end
            cut_len = (r[6:3] == 4'd0) ? 1 + int'(r[15:8] % 10) : 0;
            r = next_rand();
            pay_len = 1 + int'(r[15:0] % 100);
            send_datagram(dst, pay_len, cut_len);
        end
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;

        // Only the reply of the last datagram can still be in flight
        drain_cycles = 0;
        while (exp_q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(negedge clk_125mhz);
            drain_cycles++;
        end
        // Quiet period so stray output or a late led check is seen
        repeat (100) @(negedge clk_125mhz);

        if (exp_q.size() == 0 && led_q.size() == 0 && !led_pending) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("Expected reply bytes were never sent");
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/udp_echo_pkg.sv
rtl/byte_stream_if.sv
rtl/udp_hdr_if.sv
rtl/udp_rx_parser.sv
rtl/echo_port_filter.sv
rtl/payload_fifo.sv
rtl/udp_tx_builder.sv
rtl/udp_echo_top.sv
verification/tb_udp_echo.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the UDP echo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_udp_echo -f files.f

out=$(./obj_dir/Vtb_udp_echo) || true
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi
